/* logic/baudTickGen.sv */
// oversampling tick generator
// programmable down counter, one-clock tick per period
`timescale 1ns/10ps
`default_nettype none

module baudTickGen (
	input logic clk,
	input logic reset,
	input uartPkg::baudDiv divisor,
	input logic restart,	// divisor just changed
	output logic sTick
);
	import uartPkg::*;

	baudDiv cnt;	// counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (restart || cnt == '0)
			cnt <= divisor;	// reload, period is divisor + 1
		else
			cnt <= cnt - 1'b1;
	end

	// tick on the zero count
	assign sTick = (cnt == '0);

endmodule

`default_nettype wire

/* logic/uartAxiRegs.sv */
// axi4-lite register block
// data / status / divisor decode, response channels, sticky overrun
`timescale 1ns/10ps
`default_nettype none

module uartAxiRegs (
	input logic clk,
	input logic reset,
	input uartPkg::axiAddrChan aw,
	input uartPkg::axiAddrChan ar,
	input uartPkg::axiDataChan w,
	input logic bReady,
	input logic rReady,
	output logic awReady,
	output logic wReady,
	output logic arReady,
	output uartPkg::axiRespChan b,
	output uartPkg::axiRespChan r,
	input uartPkg::dataByte rxData,	// head of rx fifo
	input logic rxEmpty,
	input logic txFull,
	input logic rxPushFull,	// rx fifo full
	input logic rxDoneTick,	// receiver push strobe
	input logic txIdle,
	output logic rxPop,
	output logic txPush,
	output logic divRestart,
	output uartPkg::dataByte txData,
	output uartPkg::baudDiv divisor
);
	import uartPkg::*;

	logic wrAcc, rdAcc;	// handshakes this cycle
	logic bValid, rValid;
	axiResp bResp, rResp;
	axiResp wrResp, rdResp;	// decoded responses
	regWord rRdData, rdData;
	logic divWrite;
	logic statusRead;
	logic rxOverrun;
	uartStatus status;

	// one outstanding transfer per direction
	assign awReady = !bValid;
	assign wReady = !bValid;
	assign arReady = !rValid;
	assign wrAcc = aw.valid && w.valid && !bValid;
	assign rdAcc = ar.valid && !rValid;

	assign status = '{
		txIdle: txIdle,
		rxOverrun: rxOverrun,
		txFull: txFull,
		rxNotEmpty: !rxEmpty
	};

	assign txData = w.data[7:0];

	//////////////////////////////////////////////////
	// write decode
	always_comb
	begin
		wrResp = respOkay;
		txPush = 1'b0;
		divWrite = 1'b0;
		if (wrAcc)
		begin
			case (aw.addr)
				regData:
					if (txFull)
						wrResp = respSlvErr;	// byte dropped
					else
						txPush = 1'b1;
				regDivisor: divWrite = 1'b1;
				default: wrResp = respSlvErr;	// status is read-only
			endcase
		end
	end

	// read decode
	always_comb
	begin
		rdResp = respOkay;
		rdData = '0;
		rxPop = 1'b0;
		statusRead = 1'b0;
		if (rdAcc)
		begin
			case (ar.addr)
				regData:
					if (rxEmpty)
						rdResp = respSlvErr;	// nothing to read, data stays 0
					else
					begin
						rxPop = 1'b1;
						rdData = regWord'(rxData);
					end
				regStatus:
				begin
					statusRead = 1'b1;
					rdData = regWord'(status);
				end
				regDivisor: rdData = regWord'(divisor);
				default: rdResp = respSlvErr;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// control state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bValid <= 1'b0;
			rValid <= 1'b0;
			rxOverrun <= 1'b0;
			divRestart <= 1'b0;
			divisor <= defaultDivisor;
		end
		else
		begin
			if (wrAcc)
				bValid <= 1'b1;
			else if (bReady)
				bValid <= 1'b0;
			if (rdAcc)
				rValid <= 1'b1;
			else if (rReady)
				rValid <= 1'b0;
			// a new overrun beats the clear from the same cycle's status read
			if (rxDoneTick && rxPushFull)
				rxOverrun <= 1'b1;
			else if (statusRead)
				rxOverrun <= 1'b0;
			if (divWrite)
				divisor <= w.data[15:0];
			divRestart <= divWrite;	// reload after the new value lands
		end
	end

	// response payload, only meaningful with valid
	always_ff @(posedge clk)
	begin
		if (wrAcc)
			bResp <= wrResp;
		if (rdAcc)
		begin
			rResp <= rdResp;
			rRdData <= rdData;
		end
	end

	assign b = '{resp: bResp, data: '0, valid: bValid};
	assign r = '{resp: rResp, data: rRdData, valid: rValid};

endmodule

`default_nettype wire

/* logic/uartFifo.sv */
// byte fifo, circular buffer
// first-word output, full / empty flags
`timescale 1ns/10ps
`default_nettype none

module uartFifo #(
	parameter int fifoAddrWidth = 4	// depth is 2**fifoAddrWidth
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input uartPkg::dataByte wData,
	output uartPkg::dataByte rData,
	output logic full,
	output logic empty
);
	import uartPkg::*;

	localparam int depth = 1 << fifoAddrWidth;

	dataByte mem [depth];
	logic [fifoAddrWidth-1:0] wrPtr, rdPtr;
	logic [fifoAddrWidth:0] count;	// one bit wider, holds depth
	logic doPush, doPop;

	// illegal requests just fall away
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wData;
	end

	assign rData = mem[rdPtr];	// oldest entry
	assign full = (count == (fifoAddrWidth + 1)'(depth));
	assign empty = (count == '0);

endmodule

`default_nettype wire

/* logic/uartPkg.sv */
// shared types for the uart peripheral
// bus channel structs, status word, fsm state enums, register map
`default_nettype none

package uartPkg;

	typedef logic [7:0] dataByte;	// one serial frame payload
	typedef logic [3:0] regAddr;	// byte address into the register map
	typedef logic [31:0] regWord;	// axi data word
	typedef logic [15:0] baudDiv;	// tick period = divisor + 1 clocks
	typedef logic [1:0] axiResp;

	localparam axiResp respOkay = 2'd0;
	localparam axiResp respSlvErr = 2'd2;

	//////////////////////////////////////////////////
	// axi4-lite channels, ready travels separately
	typedef struct packed {
		regAddr addr;
		logic valid;
	} axiAddrChan;	// aw and ar

	typedef struct packed {
		regWord data;
		logic valid;
	} axiDataChan;	// w, no strobes

	typedef struct packed {
		axiResp resp;
		regWord data;	// unused on b
		logic valid;
	} axiRespChan;	// b and r

	// status register, rxNotEmpty lands on bit 0
	typedef struct packed {
		logic txIdle;
		logic rxOverrun;	// sticky until status read
		logic txFull;
		logic rxNotEmpty;
	} uartStatus;

	typedef enum logic [1:0] {rIdle, rStart, rData, rStop} rxState;
	typedef enum logic [1:0] {tIdle, tStart, tData, tStop} txState;

	// register map
	localparam regAddr regData = 4'h0;
	localparam regAddr regStatus = 4'h4;
	localparam regAddr regDivisor = 4'h8;

	localparam baudDiv defaultDivisor = 16'd3;

endpackage

`default_nettype wire

/* logic/uartRec.sv */
// serial receiver, 16x oversampled
// start / data / stop fsm, 8 data bits lsb first
`timescale 1ns/10ps
`default_nettype none

module uartRec #(
	parameter int stopTicks = 16	// 16, 24 or 32 ticks of stop
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output uartPkg::dataByte dOut
);
	import uartPkg::*;

	// tick counter must reach both 15 and stopTicks-1
	localparam int cntMax = (stopTicks > 16) ? stopTicks : 16;
	localparam int cntW = $clog2(cntMax);

	rxState stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;	// tick counter
	logic [2:0] nReg, nNext;	// bit counter
	dataByte bReg, bNext;	// shift register
	logic [1:0] rxSync;	// rx comes from outside the clock domain
	logic rxIn;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rxSync <= 2'b11;	// idle line is high
		else
			rxSync <= {rxSync[0], rx};
	end
	assign rxIn = rxSync[1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////
	// next state
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			rIdle:
				if (!rxIn)	// falling start edge
				begin
					stateNext = rStart;
					sNext = '0;
				end
			rStart:
				if (sTick)
				begin
					if (sReg == cntW'(7))	// middle of start bit
					begin
						stateNext = rxIn ? rIdle : rData;	// high here is a glitch
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			rData:
				if (sTick)
				begin
					if (sReg == cntW'(15))	// middle of next bit
					begin
						sNext = '0;
						bNext = {rxIn, bReg[7:1]};	// lsb arrives first
						if (nReg == 3'd7)
							stateNext = rStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rStop:
				if (sTick)
				begin
					if (sReg == cntW'(stopTicks - 1))
					begin
						stateNext = rIdle;
						rxDoneTick = 1'b1;	// byte complete in bReg
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = rIdle;
		endcase
	end

	assign dOut = bReg;

endmodule

`default_nettype wire

/* logic/uartTop.sv */
// uart peripheral top level
// tick generator, receiver, transmitter, two fifos, axi register block
`timescale 1ns/10ps
`default_nettype none

module uartTop #(
	parameter int fifoAddrWidth = 4,	// 16 entries per fifo
	parameter int stopTicks = 16
) (
	input logic clk,
	input logic reset,
	input uartPkg::axiAddrChan aw,
	input uartPkg::axiDataChan w,
	input uartPkg::axiAddrChan ar,
	input logic bReady,
	input logic rReady,
	output logic awReady,
	output logic wReady,
	output logic arReady,
	output uartPkg::axiRespChan b,
	output uartPkg::axiRespChan r,
	input logic rx,
	output logic tx
);
	import uartPkg::*;

	logic sTick, rxDoneTick;
	logic rxPop, rxEmpty, rxFull;
	logic txPush, txEmpty, txFull, txReady, txStart, txIdle;
	logic divRestart;
	dataByte rxByte, rxHead;	// receiver out, fifo head
	dataByte txByteIn, txHead;
	baudDiv divisor;

	// hand the next byte over as soon as the transmitter is free
	assign txStart = txReady && !txEmpty;
	assign txIdle = txReady && txEmpty;

	baudTickGen tickGen (.clk(clk), .reset(reset), .divisor(divisor),
		.restart(divRestart), .sTick(sTick));

	uartRec #(.stopTicks(stopTicks)) receiver (.clk(clk), .reset(reset),
		.sTick(sTick), .rx(rx), .rxDoneTick(rxDoneTick), .dOut(rxByte));

	uartTrans #(.stopTicks(stopTicks)) transmitter (.clk(clk), .reset(reset),
		.sTick(sTick), .start(txStart), .dIn(txHead), .tx(tx), .txReady(txReady));

	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) rxFifo (.clk(clk), .reset(reset),
		.push(rxDoneTick), .pop(rxPop), .wData(rxByte), .rData(rxHead),
		.full(rxFull), .empty(rxEmpty));

	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) txFifo (.clk(clk), .reset(reset),
		.push(txPush), .pop(txStart), .wData(txByteIn), .rData(txHead),
		.full(txFull), .empty(txEmpty));

	uartAxiRegs regs (.clk(clk), .reset(reset), .aw(aw), .ar(ar), .w(w),
		.bReady(bReady), .rReady(rReady), .awReady(awReady), .wReady(wReady),
		.arReady(arReady), .b(b), .r(r), .rxData(rxHead), .rxEmpty(rxEmpty),
		.txFull(txFull), .rxPushFull(rxFull), .rxDoneTick(rxDoneTick),
		.txIdle(txIdle), .rxPop(rxPop), .txPush(txPush), .divRestart(divRestart),
		.txData(txByteIn), .divisor(divisor));

endmodule

`default_nettype wire

/* logic/uartTrans.sv */
// serial transmitter, 16 ticks per bit
// start bit, 8 data bits lsb first, programmable stop period
`timescale 1ns/10ps
`default_nettype none

module uartTrans #(
	parameter int stopTicks = 16
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic start,	// load dIn and begin a frame
	input uartPkg::dataByte dIn,
	output logic tx,
	output logic txReady
);
	import uartPkg::*;

	localparam int cntMax = (stopTicks > 16) ? stopTicks : 16;
	localparam int cntW = $clog2(cntMax);

	txState stateReg, stateNext;
	logic [cntW-1:0] sReg, sNext;	// ticks within a bit
	logic [2:0] nReg, nNext;	// data bit index
	dataByte bReg, bNext;	// byte being shifted out
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= tIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////
	// frame sequencing
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		case (stateReg)
			tIdle:
			begin
				txNext = 1'b1;
				if (start)
				begin
					stateNext = tStart;
					sNext = '0;
					bNext = dIn;
				end
			end
			tStart:
			begin
				txNext = 1'b0;	// start bit
				if (sTick)
				begin
					if (sReg == cntW'(15))
					begin
						stateNext = tData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			tData:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == cntW'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit into position 0
						if (nReg == 3'd7)
							stateNext = tStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			tStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == cntW'(stopTicks - 1))
						stateNext = tIdle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default:
				stateNext = tIdle;
		endcase
	end

	assign tx = txReg;
	assign txReady = (stateReg == tIdle);

endmodule

`default_nettype wire

/* project.f */
logic/uartPkg.sv
logic/baudTickGen.sv
logic/uartRec.sv
logic/uartTrans.sv
logic/uartFifo.sv
logic/uartAxiRegs.sv
logic/uartTop.sv
tests/uartTop_sva.sv
tests/uartTopTb.sv

/* tests/uartTopTb.sv */
// testbench for the uart peripheral
// axi host tasks, rx frame driver, tx monitor, queue model, watchdog
`timescale 1ns/10ps
`default_nettype none

module uartTopTb;
	import uartPkg::*;

	localparam int fifoDepth = 16;
	localparam int totalFrames = 8 + 8 + 17 + 4 + 4;
	localparam int watchdogNs = totalFrames * 160 * 8 * 40 * 2;	// worst divisor 7

	logic clk, reset;
	axiAddrChan aw, ar;
	axiDataChan w;
	axiRespChan b, r;
	logic bReady, rReady, awReady, wReady, arReady;
	logic rx, tx;

	integer seed;
	int curDiv;	// divisor the serial side runs at
	logic overrunExp;
	dataByte txExp[$];	// bytes still due on tx
	dataByte rxExp[$];	// bytes held in the rx fifo

	uartTop #(.fifoAddrWidth(4), .stopTicks(16)) uartTop_inst (.clk(clk), .reset(reset),
		.aw(aw), .w(w), .ar(ar), .bReady(bReady), .rReady(rReady), .awReady(awReady),
		.wReady(wReady), .arReady(arReady), .b(b), .r(r), .rx(rx), .tx(tx));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// axi host tasks start right after a rising edge
	task automatic writeReg(input regAddr a, input regWord d, output axiResp rsp);
		int gap;
		gap = $random(seed) & 3;
		aw <= '{addr: a, valid: 1'b1};
		w <= '{data: d, valid: 1'b1};
		do
			@(posedge clk);
		while (!(awReady && wReady));
		aw.valid <= 1'b0;
		w.valid <= 1'b0;
		@(posedge clk);
		checkEq(b.valid, 1'b1, "write response one cycle after accept");
		checkEq({awReady, wReady}, 2'b00, "write channels stalled while b pending");
		repeat (gap) @(posedge clk);	// host stalls b
		bReady <= 1'b1;
		@(posedge clk);
		rsp = b.resp;
		bReady <= 1'b0;
	endtask

	task automatic readReg(input regAddr a, output regWord d, output axiResp rsp);
		int gap;
		gap = $random(seed) & 3;
		ar <= '{addr: a, valid: 1'b1};
		do
			@(posedge clk);
		while (!arReady);
		ar.valid <= 1'b0;
		@(posedge clk);
		checkEq(r.valid, 1'b1, "read response one cycle after accept");
		checkEq(arReady, 1'b0, "read address stalled while r pending");
		repeat (gap) @(posedge clk);
		rReady <= 1'b1;
		@(posedge clk);
		d = r.data;
		rsp = r.resp;
		rReady <= 1'b0;
	endtask

	// status bits 0..3 are rxNotEmpty, txFull, rxOverrun, txIdle
	task automatic checkStatus(input string what);
		regWord st;
		axiResp rsp;
		readReg(regStatus, st, rsp);
		checkEq(rsp, respOkay, what);
		checkEq(st, {28'd0, 1'b1, overrunExp, 1'b0, rxExp.size() != 0}, what);
		overrunExp = 1'b0;	// cleared by the read
	endtask

	task automatic waitTxIdle();
		regWord st;
		axiResp rsp;
		do
			readReg(regStatus, st, rsp);
		while (!st[3]);
	endtask

	task automatic waitRxReady();
		regWord st;
		axiResp rsp;
		do
			readReg(regStatus, st, rsp);
		while (!st[0]);
	endtask

	//////////////////////////////////////////////////
	// serial side and model
	task automatic sendFrame(input dataByte d);
		int bitClks;
		bitClks = 16 * (curDiv + 1);
		rx <= 1'b0;	// start bit
		repeat (bitClks) @(posedge clk);
		for (int i = 0; i < 8; i++)
		begin
			rx <= d[i];	// lsb first
			repeat (bitClks) @(posedge clk);
		end
		rx <= 1'b1;
		repeat (bitClks) @(posedge clk);
	endtask

	task automatic rxFrames(input int n);
		dataByte d;
		for (int i = 0; i < n; i++)
		begin
			d = $random(seed);
			sendFrame(d);
			if (rxExp.size() < fifoDepth)
				rxExp.push_back(d);
			else
				overrunExp = 1'b1;	// full fifo drops it
		end
	endtask

	task automatic drainRx();
		regWord d;
		axiResp rsp;
		while (rxExp.size() != 0)
		begin
			readReg(regData, d, rsp);
			checkEq(rsp, respOkay, "rx data read response");
			checkEq(d, rxExp.pop_front(), "rx byte");
		end
	endtask

	task automatic txBurst(input int n);
		regWord d;
		axiResp rsp;
		for (int i = 0; i < n; i++)
		begin
			d = $random(seed) & 32'hff;
			txExp.push_back(d[7:0]);
			writeReg(regData, d, rsp);
			checkEq(rsp, respOkay, "tx data write response");
		end
		while (txExp.size() != 0)
			@(posedge clk);	// monitor empties the queue
		waitTxIdle();
	endtask

	// tx monitor samples mid bit
	initial
	begin
		dataByte got;
		int bitClks;
		forever
		begin
			@(posedge clk);
			if (reset === 1'b0 && tx === 1'b0)
			begin
				bitClks = 16 * (curDiv + 1);
				repeat (bitClks / 2) @(posedge clk);
				checkEq(tx, 1'b0, "tx start bit");
				for (int i = 0; i < 8; i++)
				begin
					repeat (bitClks) @(posedge clk);
					got[i] = tx;
				end
				repeat (bitClks) @(posedge clk);
				checkEq(tx, 1'b1, "tx stop bit");
				checkEq(txExp.size() != 0, 1'b1, "tx byte with nothing expected");
				checkEq(got, txExp.pop_front(), "tx byte");
			end
		end
	end

	initial
	begin
		#(watchdogNs);
		$display("ERROR: run timed out after %0d ns", watchdogNs);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////
	// test sequence
	initial
	begin
		regWord d;
		axiResp rsp;
		int newDiv;
		seed = 32'he38f;
		curDiv = 3;
		overrunExp = 1'b0;
		reset = 1'b1;
		aw = '0;
		ar = '0;
		w = '0;
		bReady = 1'b0;
		rReady = 1'b0;
		rx = 1'b1;	// idle line
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		readReg(regDivisor, d, rsp);
		checkEq(d, 32'd3, "divisor after reset");
		checkEq(rsp, respOkay, "divisor read response");
		checkStatus("status after reset");

		txBurst(8);

		rxFrames(8);
		waitRxReady();
		drainRx();
		checkStatus("status after rx drain");

		// one frame past the fifo depth
		rxFrames(fifoDepth + 1);
		checkStatus("status with overrun");
		checkStatus("overrun cleared by status read");
		drainRx();
		checkStatus("status after overrun drain");

		// error responses
		readReg(regData, d, rsp);
		checkEq(rsp, respSlvErr, "read of empty rx fifo");
		checkEq(d, 32'd0, "data of empty rx read");
		readReg(4'hC, d, rsp);
		checkEq(rsp, respSlvErr, "unmapped read");
		checkEq(d, 32'd0, "data of unmapped read");
		writeReg(regStatus, 32'hF, rsp);
		checkEq(rsp, respSlvErr, "write to status");
		writeReg(4'hC, 32'h55, rsp);
		checkEq(rsp, respSlvErr, "unmapped write");
		checkStatus("status after error accesses");
		readReg(regDivisor, d, rsp);
		checkEq(d, 32'd3, "divisor after error accesses");

		// new rate between 4 and 7
		newDiv = 4 + ($random(seed) & 3);
		writeReg(regDivisor, newDiv, rsp);
		checkEq(rsp, respOkay, "divisor write response");
		curDiv = newDiv;
		readReg(regDivisor, d, rsp);
		checkEq(d, newDiv, "divisor readback");
		txBurst(4);
		rxFrames(4);
		waitRxReady();
		drainRx();
		checkStatus("status after new rate");

		if (uartTop_inst.svaChecks.assertFails == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/uartTop_sva.sv */
// bound assertions for the uart top level
// rx done on tick, b / r hold until ready, tx idle level
`timescale 1ns/10ps
`default_nettype none

module uartTopSva (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rxDoneTick,
	input uartPkg::axiRespChan b,
	input logic bReady,
	input uartPkg::axiRespChan r,
	input logic rReady,
	input logic txReady,
	input logic tx
);
	int assertFails = 0;	// polled by the testbench at the end

	// receiver only finishes on an oversampling tick
	rxDoneOnTick: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> sTick)
	else
	begin
		$error("rxDoneTick without sTick");
		assertFails++;
	end

	bHeld: assert property (@(posedge clk) disable iff (reset)
		b.valid && !bReady |=> b.valid)
	else
	begin
		$error("write response dropped before bReady");
		assertFails++;
	end

	rHeld: assert property (@(posedge clk) disable iff (reset)
		r.valid && !rReady |=> r.valid)
	else
	begin
		$error("read response dropped before rReady");
		assertFails++;
	end

	// line must idle high
	txIdleHigh: assert property (@(posedge clk) disable iff (reset)
		txReady |-> tx)
	else
	begin
		$error("tx low while transmitter idle");
		assertFails++;
	end

endmodule

bind uartTop uartTopSva svaChecks (.clk(clk), .reset(reset), .sTick(sTick),
	.rxDoneTick(rxDoneTick), .b(b), .bReady(bReady), .r(r), .rReady(rReady),
	.txReady(txReady), .tx(tx));

`default_nettype wire
